//--- tb.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_stage_if.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

//--- Makefile
SIM   ?= verilator
TOP   ?= rv_core_tb
FLIST ?= tb.f
OBJ   ?= obj_dir
FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP)

lint:
	$(SIM) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ)

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int imem_words = 256;
  localparam int dmem_words = 512;
  // operands at byte 0x400, results from byte 0x600
  localparam int src_idx = 128;
  localparam int res_idx = 192;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic        clk;
  logic        rst;
  logic [63:0] imem_addr;
  logic [31:0] imem_data;
  logic [63:0] dmem_addr;
  logic [63:0] dmem_rdata;
  logic [63:0] dmem_wdata;
  logic [7:0]  dmem_wmask;
  logic        dmem_we;
  logic        illegal;
  logic        halted;

  logic [31:0] imem [imem_words];
  logic [63:0] dmem [dmem_words];
  logic [31:0] prog [$];
  logic [63:0] expect_q [$];
  logic [63:0] trace [$];
  logic [63:0] trace_exp [$];
  int          illegal_count;
  logic [63:0] illegal_pc;
  realtime     deadline = 200.0;

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .illegal    (illegal),
    .halted     (halted)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // memories answer combinationally
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[11:3]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < 8; i++) begin
        if (dmem_wmask[i]) begin
          dmem[dmem_addr[11:3]][i*8 +: 8] = dmem_wdata[i*8 +: 8];
        end
      end
    end
  end

  // instruction formats
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [63:0] sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // keep the low bytes, fill the rest with zeros or the sign bit
  function automatic logic [63:0] extend(logic [63:0] v, int bytes, bit uns);
    logic [63:0] r;
    r = v;
    for (int i = bytes * 8; i < 64; i++) begin
      r[i] = uns ? 1'b0 : v[bytes*8-1];
    end
    return r;
  endfunction

  function automatic bit branch_taken(logic [2:0] f3, logic [63:0] x, logic [63:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("FAIL %s: got 0x%h expected 0x%h", name, act, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // straight-line instruction whose pc is expected in the trace
  task automatic emit(input logic [31:0] w);
    trace_exp.push_back(64'(prog.size() * 4));
    prog.push_back(w);
  endtask

  task automatic emit_skipped(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic store_reg(input logic [4:0] rs, input logic [63:0] exp);
    emit(s_type(12'(expect_q.size() * 8), rs, 5'd2, 3'b011));
    expect_q.push_back(exp);
  endtask

  // instruction writes x5, which then goes to the next result slot
  task automatic store_result(input logic [31:0] w, input logic [63:0] exp);
    emit(w);
    store_reg(5'd5, exp);
  endtask

  task automatic fill_dmem();
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i] = {i, ~i} ^ 64'ha5a5_0f0f_5a5a_f0f0;
    end
  endtask

  task automatic preamble();
    prog.delete();
    expect_q.delete();
    trace_exp.delete();
    emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(i_type(12'h600, 5'd0, 3'b000, 5'd2, 7'b0010011));
  endtask

  task automatic ld_reg(input logic [4:0] rd, input logic [11:0] off);
    emit(i_type(off, 5'd1, 3'b011, rd, 7'b0000011));
  endtask

  // load program, reset the core and record pcs until it halts
  task automatic load_and_run();
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : ebreak_word;
    end
    trace_exp.push_back(64'(prog.size() * 4));
    deadline = $realtime + (prog.size() + 8 + 40) * 4.0;
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (8) begin
      @(posedge clk);
      #1;
    end
    rst = 1'b0;
    trace.delete();
    illegal_count = 0;
    while (!halted) begin
      trace.push_back(imem_addr);
      if (illegal) begin
        illegal_count++;
        illegal_pc = imem_addr;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic compare_results(input string tag);
    for (int k = 0; k < expect_q.size(); k++) begin
      check($sformatf("%s dmem[%0d]", tag, res_idx + k), dmem[res_idx + k], expect_q[k]);
    end
  endtask

  task automatic alu_test();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] immx;
    logic [11:0] imm;
    a = rand64();
    b = rand64();
    // register shift amount above 31
    b[5] = 1'b1;
    imm = 12'h9a5;
    immx = {{52{imm[11]}}, imm};
    fill_dmem();
    dmem[src_idx] = a;
    dmem[src_idx + 1] = b;
    dmem[src_idx + 2] = 64'h7fff_ffff;
    preamble();
    ld_reg(5'd3, 12'd0);
    ld_reg(5'd4, 12'd8);
    ld_reg(5'd6, 12'd16);
    store_result(r_type(7'h00, 4, 3, 3'b000, 5, 7'b0110011), a + b);
    store_result(r_type(7'h20, 4, 3, 3'b000, 5, 7'b0110011), a - b);
    store_result(r_type(7'h00, 4, 3, 3'b001, 5, 7'b0110011), a << b[5:0]);
    store_result(r_type(7'h00, 4, 3, 3'b010, 5, 7'b0110011),
                 ($signed(a) < $signed(b)) ? 64'd1 : 64'd0);
    store_result(r_type(7'h00, 4, 3, 3'b011, 5, 7'b0110011), (a < b) ? 64'd1 : 64'd0);
    store_result(r_type(7'h00, 4, 3, 3'b100, 5, 7'b0110011), a ^ b);
    store_result(r_type(7'h00, 4, 3, 3'b101, 5, 7'b0110011), a >> b[5:0]);
    store_result(r_type(7'h20, 4, 3, 3'b101, 5, 7'b0110011), $signed(a) >>> b[5:0]);
    store_result(r_type(7'h00, 4, 3, 3'b110, 5, 7'b0110011), a | b);
    store_result(r_type(7'h00, 4, 3, 3'b111, 5, 7'b0110011), a & b);
    // word forms
    store_result(r_type(7'h00, 4, 3, 3'b000, 5, 7'b0111011), sext32(a[31:0] + b[31:0]));
    store_result(r_type(7'h20, 4, 3, 3'b000, 5, 7'b0111011), sext32(a[31:0] - b[31:0]));
    store_result(r_type(7'h00, 4, 3, 3'b001, 5, 7'b0111011), sext32(a[31:0] << b[4:0]));
    store_result(r_type(7'h00, 4, 3, 3'b101, 5, 7'b0111011), sext32(a[31:0] >> b[4:0]));
    store_result(r_type(7'h20, 4, 3, 3'b101, 5, 7'b0111011),
                 sext32($signed(a[31:0]) >>> b[4:0]));
    // immediate forms with a negative immediate
    store_result(i_type(imm, 3, 3'b000, 5, 7'b0010011), a + immx);
    store_result(i_type(imm, 3, 3'b010, 5, 7'b0010011),
                 ($signed(a) < $signed(immx)) ? 64'd1 : 64'd0);
    store_result(i_type(imm, 3, 3'b011, 5, 7'b0010011), (a < immx) ? 64'd1 : 64'd0);
    store_result(i_type(imm, 3, 3'b100, 5, 7'b0010011), a ^ immx);
    store_result(i_type(imm, 3, 3'b110, 5, 7'b0010011), a | immx);
    store_result(i_type(imm, 3, 3'b111, 5, 7'b0010011), a & immx);
    store_result(i_type({6'b000000, 6'd40}, 3, 3'b001, 5, 7'b0010011), a << 40);
    store_result(i_type({6'b000000, 6'd35}, 3, 3'b101, 5, 7'b0010011), a >> 35);
    store_result(i_type({6'b010000, 6'd63}, 3, 3'b101, 5, 7'b0010011), $signed(a) >>> 63);
    store_result(i_type(imm, 3, 3'b000, 5, 7'b0011011), sext32(a[31:0] + immx[31:0]));
    // carry into bit 31 gives a negative word
    store_result(i_type(12'd1, 6, 3'b000, 5, 7'b0011011), 64'hffff_ffff_8000_0000);
    store_result(i_type({7'h00, 5'd31}, 3, 3'b001, 5, 7'b0011011), sext32(a[31:0] << 31));
    store_result(i_type({7'h00, 5'd7}, 3, 3'b101, 5, 7'b0011011), sext32(a[31:0] >> 7));
    store_result(i_type({7'h20, 5'd20}, 3, 3'b101, 5, 7'b0011011),
                 sext32($signed(a[31:0]) >>> 20));
    store_result(u_type(20'h80001, 5, 7'b0110111), sext32(32'h8000_1000));
    load_and_run();
    compare_results("alu");
  endtask

  task automatic load_test();
    logic [63:0] d;
    int          bytes;
    d = rand64();
    fill_dmem();
    dmem[src_idx] = d;
    preamble();
    for (int sz = 0; sz < 4; sz++) begin
      bytes = 1 << sz;
      for (int off = 0; off + bytes <= 8; off++) begin
        store_result(i_type(12'(off), 5'd1, 3'(sz), 5'd5, 7'b0000011),
                     extend(d >> (off * 8), bytes, 1'b0));
        if (sz < 3) begin
          store_result(i_type(12'(off), 5'd1, 3'(sz + 4), 5'd5, 7'b0000011),
                       extend(d >> (off * 8), bytes, 1'b1));
        end
      end
    end
    load_and_run();
    compare_results("load");
  endtask

  task automatic store_test();
    logic [63:0] v;
    logic [63:0] p;
    logic [63:0] e;
    int          bytes;
    int          k;
    v = rand64();
    fill_dmem();
    dmem[src_idx] = v;
    preamble();
    ld_reg(5'd3, 12'd0);
    k = 0;
    for (int sz = 0; sz < 3; sz++) begin
      bytes = 1 << sz;
      for (int off = 0; off + bytes <= 8; off++) begin
        p = rand64();
        dmem[res_idx + k] = p;
        e = p;
        for (int i = 0; i < bytes; i++) begin
          e[(off+i)*8 +: 8] = v[i*8 +: 8];
        end
        emit(s_type(12'(k * 8 + off), 5'd3, 5'd2, 3'(sz)));
        expect_q.push_back(e);
        k++;
      end
    end
    load_and_run();
    compare_results("store");
  endtask

  task automatic control_test();
    logic [63:0] vals [4];
    logic [4:0]  regs [4];
    logic [2:0]  f3s [6];
    logic [63:0] link;
    bit          taken;
    vals = '{rand64(), rand64(), 64'hffff_ffff_ffff_ffff, 64'd1};
    regs = '{5'd3, 5'd4, 5'd6, 5'd7};
    f3s  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    fill_dmem();
    for (int i = 0; i < 4; i++) begin
      dmem[src_idx + i] = vals[i];
    end
    preamble();
    for (int i = 0; i < 4; i++) begin
      ld_reg(regs[i], 12'(i * 8));
    end
    // operand pairs are equal, random, -1 against 1 and 1 against -1
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < 4; p++) begin
        int x;
        int y;
        x = (p == 0) ? 0 : (p == 1) ? 0 : (p == 2) ? 2 : 3;
        y = (p == 0) ? 0 : (p == 1) ? 1 : (p == 2) ? 3 : 2;
        taken = branch_taken(f3s[b], vals[x], vals[y]);
        emit(b_type(13'd8, regs[y], regs[x], f3s[b]));
        if (taken) begin
          emit_skipped(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
        end else begin
          emit(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
        end
      end
    end
    link = 64'(prog.size() * 4 + 4);
    emit(j_type(21'd12, 5'd9));
    emit_skipped(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    emit_skipped(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    store_reg(5'd9, link);
    // jalr with an odd offset from the auipc base lands on base plus 16
    link = 64'(prog.size() * 4);
    emit(u_type(20'd0, 5'd10, 7'b0010111));
    emit(i_type(12'd17, 5'd10, 3'b000, 5'd11, 7'b1100111));
    emit_skipped(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    emit_skipped(i_type(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    store_reg(5'd10, link);
    store_reg(5'd11, link + 64'd8);
    load_and_run();
    compare_results("control");
    check("trace length", trace.size(), trace_exp.size());
    for (int i = 0; i < trace.size(); i++) begin
      check($sformatf("imem_addr step %0d", i), trace[i], trace_exp[i]);
    end
  endtask

  task automatic trap_test();
    logic [63:0] bad_pc;
    logic [63:0] frozen;
    fill_dmem();
    preamble();
    emit(i_type(12'h011, 5'd0, 3'b000, 5'd5, 7'b0010011));
    bad_pc = 64'(prog.size() * 4);
    emit(32'hffff_ffff);
    emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, 7'b0010011));
    store_reg(5'd5, 64'h12);
    load_and_run();
    compare_results("trap");
    check("illegal pulse count", illegal_count, 1);
    check("illegal pc", illegal_pc, bad_pc);
    // a store under the frozen pc must stay inert
    frozen = imem_addr;
    imem[frozen[9:2]] = s_type(12'd0, 5'd5, 5'd2, 3'b011);
    repeat (10) begin
      @(posedge clk);
      #1;
      check("imem_addr", imem_addr, frozen);
      check("dmem_we", dmem_we, 1'b0);
      check("halted", halted, 1'b1);
      check("illegal", illegal, 1'b0);
    end
  endtask

  initial begin
    rst = 1'b1;
    void'($urandom(48027));
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = ebreak_word;
    end
    fill_dmem();
    alu_test();
    load_test();
    store_test();
    control_test();
    trap_test();
    if (rv_core_i.chk_i.fail_count != 0) begin
      $display("bound checker saw %0d assertion failures", rv_core_i.chk_i.fail_count);
      $display("Test FAILED");
      $fatal(1);
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // deadline moves forward with every program loaded
  initial begin
    while ($realtime < deadline) begin
      #4;
    end
    $display("watchdog: core never halted before the deadline");
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

//--- dv/rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
  input logic        clk,
  input logic        rst,
  input logic [63:0] imem_addr,
  input logic        dmem_we,
  input logic [7:0]  dmem_wmask,
  input logic        illegal,
  input logic        halted
);

  int fail_count;

  // a store enables at least one lane
  wmask_nonzero: assert property (@(posedge clk) disable iff (rst)
    dmem_we |-> dmem_wmask != 8'h00)
    else begin
      fail_count++;
      $error("store with an empty byte mask");
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    imem_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("fetch address not word aligned");
    end

  // only reset clears halted
  halt_sticky: assert property (@(posedge clk)
    $fell(halted) |-> $past(rst))
    else begin
      fail_count++;
      $error("halted dropped without reset");
    end

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (!illegal && !dmem_we))
    else begin
      fail_count++;
      $error("illegal or store right after reset");
    end

endmodule

bind rv_core rv_core_chk chk_i (
  .clk        (clk),
  .rst        (rst),
  .imem_addr  (imem_addr),
  .dmem_we    (dmem_we),
  .dmem_wmask (dmem_wmask),
  .illegal    (illegal),
  .halted     (halted)
);

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_ILEN-1:0] imem_data,
  output logic [`RV_XLEN-1:0] dmem_addr,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [7:0]          dmem_wmask,
  output logic                dmem_we,
  output logic                illegal,
  output logic                halted
);

  rv_pkg::reg_idx_t    raddr1;
  rv_pkg::reg_idx_t    raddr2;
  logic [`RV_XLEN-1:0] rdata1;
  logic [`RV_XLEN-1:0] rdata2;
  logic [`RV_XLEN-1:0] next_pc;
  logic                wen;
  rv_pkg::reg_idx_t    waddr;
  logic [`RV_XLEN-1:0] wdata;

  issue_if  issue ();
  commit_if commit ();

  rv_regfile regfile_i (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (wen),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  rv_decode decode_i (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .next_pc   (next_pc),
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .issue     (issue.producer),
    .illegal   (illegal),
    .halted    (halted)
  );

  rv_execute execute_i (
    .issue   (issue.consumer),
    .commit  (commit.producer),
    .next_pc (next_pc)
  );

  rv_result result_i (
    .clk        (clk),
    .rst        (rst),
    .commit     (commit.consumer),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .wen        (wen),
    .waddr      (waddr),
    .wdata      (wdata)
  );

endmodule

//--- verilog/rv_result.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_result (
  input  logic                clk,
  input  logic                rst,
  commit_if.consumer          commit,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [7:0]          dmem_wmask,
  output logic                dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                wen,
  output rv_pkg::reg_idx_t    waddr,
  output logic [`RV_XLEN-1:0] wdata
);

  rv_pkg::mem_size_e   size;
  logic                is_load;
  logic                is_store;
  logic                is_unsigned;
  logic                writes_rd;
  logic [2:0]          offset;
  logic [`RV_XLEN-1:0] lane_data;
  logic [`RV_XLEN-1:0] load_val;
  logic [`RV_XLEN-1:0] store_lanes;
  logic [7:0]          size_mask;
  logic [`RV_XLEN-1:0] wdata_q;

  always_comb begin
    size        = rv_pkg::size_double;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    writes_rd   = 1'b1;
    case (commit.op)
      rv_pkg::op_lb, rv_pkg::op_lbu, rv_pkg::op_sb: size = rv_pkg::size_byte;
      rv_pkg::op_lh, rv_pkg::op_lhu, rv_pkg::op_sh: size = rv_pkg::size_half;
      rv_pkg::op_lw, rv_pkg::op_lwu, rv_pkg::op_sw: size = rv_pkg::size_word;
      default: ;
    endcase
    case (commit.op)
      rv_pkg::op_lb, rv_pkg::op_lh, rv_pkg::op_lw, rv_pkg::op_ld: is_load = 1'b1;
      rv_pkg::op_lbu, rv_pkg::op_lhu, rv_pkg::op_lwu: {is_load, is_unsigned} = 2'b11;
      rv_pkg::op_sb, rv_pkg::op_sh, rv_pkg::op_sw, rv_pkg::op_sd: begin
        {is_store, writes_rd} = 2'b10;
      end
      rv_pkg::op_beq, rv_pkg::op_bne, rv_pkg::op_blt, rv_pkg::op_bge,
      rv_pkg::op_bltu, rv_pkg::op_bgeu, rv_pkg::op_ebreak,
      rv_pkg::op_illegal: writes_rd = 1'b0;
      default: ;
    endcase
  end

  assign offset    = commit.addr[2:0];
  assign dmem_addr = {commit.addr[`RV_XLEN-1:3], 3'b000};

  // bring the addressed bytes down to lane zero, then extend
  assign lane_data = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (size)
      rv_pkg::size_byte: load_val = is_unsigned ? {56'b0, lane_data[7:0]} : `RV_SEXT(lane_data, 8);
      rv_pkg::size_half: load_val = is_unsigned ? {48'b0, lane_data[15:0]} : `RV_SEXT(lane_data, 16);
      rv_pkg::size_word: load_val = is_unsigned ? {32'b0, lane_data[31:0]} : `RV_SEXT(lane_data, 32);
      default:           load_val = lane_data;
    endcase
  end

  // stores move data and byte enables up to the addressed lanes
  always_comb begin
    case (size)
      rv_pkg::size_byte: size_mask = 8'h01;
      rv_pkg::size_half: size_mask = 8'h03;
      rv_pkg::size_word: size_mask = 8'h0f;
      default:           size_mask = 8'hff;
    endcase
  end

  assign store_lanes = commit.store_data << {offset, 3'b000};
  assign dmem_we     = is_store;
  assign dmem_wmask  = is_store ? (size_mask << offset) : 8'h00;

  // write bus keeps the last store value so it does not toggle on other ops
  always_ff @(posedge clk) begin
    if (rst) begin
      wdata_q <= '0;
    end else if (is_store) begin
      wdata_q <= store_lanes;
    end
  end

  assign dmem_wdata = is_store ? store_lanes : wdata_q;

  assign wen   = writes_rd && (commit.rd != 5'd0);
  assign waddr = commit.rd;
  assign wdata = is_load ? load_val : commit.alu_result;

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_execute (
  issue_if.consumer           issue,
  commit_if.producer          commit,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] alu;
  logic [31:0]         word_res;
  logic [`RV_XLEN-1:0] word_sext;
  logic [5:0]          shamt;
  logic [4:0]          shamt_w;
  logic                take;

  assign pc_plus4 = issue.pc + 64'd4;
  assign shamt    = issue.src2[5:0];
  assign shamt_w  = issue.src2[4:0];

  // 32-bit forms work on the low word only
  always_comb begin
    word_res = '0;
    case (issue.op)
      rv_pkg::op_addw, rv_pkg::op_addiw: word_res = issue.src1[31:0] + issue.src2[31:0];
      rv_pkg::op_subw:                   word_res = issue.src1[31:0] - issue.src2[31:0];
      rv_pkg::op_sllw, rv_pkg::op_slliw: word_res = issue.src1[31:0] << shamt_w;
      rv_pkg::op_srlw, rv_pkg::op_srliw: word_res = issue.src1[31:0] >> shamt_w;
      rv_pkg::op_sraw, rv_pkg::op_sraiw: word_res = $signed(issue.src1[31:0]) >>> shamt_w;
      default: ;
    endcase
  end

  assign word_sext = `RV_SEXT(word_res, 32);

  always_comb begin
    alu     = '0;
    take    = 1'b0;
    next_pc = pc_plus4;
    case (issue.op)
      rv_pkg::op_lui:   alu = issue.src2;
      rv_pkg::op_auipc: alu = issue.src1 + issue.src2;
      rv_pkg::op_jal: begin
        alu     = pc_plus4;
        next_pc = issue.src1 + issue.src2;
      end
      rv_pkg::op_jalr: begin
        alu     = pc_plus4;
        next_pc = (issue.src1 + issue.src2) & ~64'd1;
      end
      rv_pkg::op_beq:  take = issue.src1 == issue.src2;
      rv_pkg::op_bne:  take = issue.src1 != issue.src2;
      rv_pkg::op_blt:  take = $signed(issue.src1) < $signed(issue.src2);
      rv_pkg::op_bge:  take = $signed(issue.src1) >= $signed(issue.src2);
      rv_pkg::op_bltu: take = issue.src1 < issue.src2;
      rv_pkg::op_bgeu: take = issue.src1 >= issue.src2;
      rv_pkg::op_add, rv_pkg::op_addi: alu = issue.src1 + issue.src2;
      rv_pkg::op_sub: alu = issue.src1 - issue.src2;
      rv_pkg::op_slt, rv_pkg::op_slti: begin
        alu = {63'b0, $signed(issue.src1) < $signed(issue.src2)};
      end
      rv_pkg::op_sltu, rv_pkg::op_sltiu: alu = {63'b0, issue.src1 < issue.src2};
      rv_pkg::op_xor, rv_pkg::op_xori: alu = issue.src1 ^ issue.src2;
      rv_pkg::op_or, rv_pkg::op_ori:   alu = issue.src1 | issue.src2;
      rv_pkg::op_and, rv_pkg::op_andi: alu = issue.src1 & issue.src2;
      rv_pkg::op_sll, rv_pkg::op_slli: alu = issue.src1 << shamt;
      rv_pkg::op_srl, rv_pkg::op_srli: alu = issue.src1 >> shamt;
      rv_pkg::op_sra, rv_pkg::op_srai: alu = $signed(issue.src1) >>> shamt;
      rv_pkg::op_addw, rv_pkg::op_addiw, rv_pkg::op_subw,
      rv_pkg::op_sllw, rv_pkg::op_slliw, rv_pkg::op_srlw,
      rv_pkg::op_srliw, rv_pkg::op_sraw, rv_pkg::op_sraiw: alu = word_sext;
      // stay on the ebreak until decode freezes the pc
      rv_pkg::op_ebreak: next_pc = issue.pc;
      default: ;
    endcase
    if (take) begin
      next_pc = issue.pc + issue.imm;
    end
  end

  assign commit.op         = issue.op;
  assign commit.alu_result = alu;
  assign commit.addr       = issue.src1 + issue.imm;
  assign commit.store_data = issue.src2;
  assign commit.rd         = issue.rd;

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decode (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_ILEN-1:0] imem_data,
  input  logic [`RV_XLEN-1:0] next_pc,
  output rv_pkg::reg_idx_t    raddr1,
  output rv_pkg::reg_idx_t    raddr2,
  input  logic [`RV_XLEN-1:0] rdata1,
  input  logic [`RV_XLEN-1:0] rdata2,
  issue_if.producer           issue,
  output logic                illegal,
  output logic                halted
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_ILEN-1:0] inst;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_pkg::op_e         dec_op;

  // pc holds once halted; ebreak itself already returns its own pc
  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
    end else begin
      if (!halted) begin
        pc <= next_pc;
      end
      if (dec_op == rv_pkg::op_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  assign imem_addr = pc;
  assign inst      = imem_data;
  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];
  assign raddr1    = inst[19:15];
  assign raddr2    = inst[24:20];

  // immediates of the five formats
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec_op = rv_pkg::op_illegal;
    case (opcode)
      7'b0110111: dec_op = rv_pkg::op_lui;
      7'b0010111: dec_op = rv_pkg::op_auipc;
      7'b1101111: dec_op = rv_pkg::op_jal;
      7'b1100111: if (funct3 == 3'b000) dec_op = rv_pkg::op_jalr;
      7'b1100011: begin
        case (funct3)
          3'b000: dec_op = rv_pkg::op_beq;
          3'b001: dec_op = rv_pkg::op_bne;
          3'b100: dec_op = rv_pkg::op_blt;
          3'b101: dec_op = rv_pkg::op_bge;
          3'b110: dec_op = rv_pkg::op_bltu;
          3'b111: dec_op = rv_pkg::op_bgeu;
          default: ;
        endcase
      end
      7'b0000011: begin
        case (funct3)
          3'b000: dec_op = rv_pkg::op_lb;
          3'b001: dec_op = rv_pkg::op_lh;
          3'b010: dec_op = rv_pkg::op_lw;
          3'b011: dec_op = rv_pkg::op_ld;
          3'b100: dec_op = rv_pkg::op_lbu;
          3'b101: dec_op = rv_pkg::op_lhu;
          3'b110: dec_op = rv_pkg::op_lwu;
          default: ;
        endcase
      end
      7'b0100011: begin
        case (funct3)
          3'b000: dec_op = rv_pkg::op_sb;
          3'b001: dec_op = rv_pkg::op_sh;
          3'b010: dec_op = rv_pkg::op_sw;
          3'b011: dec_op = rv_pkg::op_sd;
          default: ;
        endcase
      end
      7'b0010011: begin
        // 64-bit shifts use a 6-bit shamt, so only inst[31:26] qualifies
        case (funct3)
          3'b000: dec_op = rv_pkg::op_addi;
          3'b010: dec_op = rv_pkg::op_slti;
          3'b011: dec_op = rv_pkg::op_sltiu;
          3'b100: dec_op = rv_pkg::op_xori;
          3'b110: dec_op = rv_pkg::op_ori;
          3'b111: dec_op = rv_pkg::op_andi;
          3'b001: if (inst[31:26] == 6'b000000) dec_op = rv_pkg::op_slli;
          3'b101: begin
            if (inst[31:26] == 6'b000000) dec_op = rv_pkg::op_srli;
            else if (inst[31:26] == 6'b010000) dec_op = rv_pkg::op_srai;
          end
          default: ;
        endcase
      end
      7'b0110011: begin
        case ({funct7, funct3})
          10'b0000000_000: dec_op = rv_pkg::op_add;
          10'b0100000_000: dec_op = rv_pkg::op_sub;
          10'b0000000_001: dec_op = rv_pkg::op_sll;
          10'b0000000_010: dec_op = rv_pkg::op_slt;
          10'b0000000_011: dec_op = rv_pkg::op_sltu;
          10'b0000000_100: dec_op = rv_pkg::op_xor;
          10'b0000000_101: dec_op = rv_pkg::op_srl;
          10'b0100000_101: dec_op = rv_pkg::op_sra;
          10'b0000000_110: dec_op = rv_pkg::op_or;
          10'b0000000_111: dec_op = rv_pkg::op_and;
          default: ;
        endcase
      end
      7'b0011011: begin
        if (funct3 == 3'b000) dec_op = rv_pkg::op_addiw;
        else if ({funct7, funct3} == 10'b0000000_001) dec_op = rv_pkg::op_slliw;
        else if ({funct7, funct3} == 10'b0000000_101) dec_op = rv_pkg::op_srliw;
        else if ({funct7, funct3} == 10'b0100000_101) dec_op = rv_pkg::op_sraiw;
      end
      7'b0111011: begin
        case ({funct7, funct3})
          10'b0000000_000: dec_op = rv_pkg::op_addw;
          10'b0100000_000: dec_op = rv_pkg::op_subw;
          10'b0000000_001: dec_op = rv_pkg::op_sllw;
          10'b0000000_101: dec_op = rv_pkg::op_srlw;
          10'b0100000_101: dec_op = rv_pkg::op_sraw;
          default: ;
        endcase
      end
      7'b1110011: if (inst == 32'h0010_0073) dec_op = rv_pkg::op_ebreak;
      default: ;
    endcase
  end

  // operand selection so execute never sees encodings
  always_comb begin
    issue.src1 = rdata1;
    issue.src2 = rdata2;
    issue.imm  = imm_i;
    case (opcode)
      7'b0110111: begin
        issue.src1 = '0;
        issue.src2 = imm_u;
      end
      7'b0010111: begin
        issue.src1 = pc;
        issue.src2 = imm_u;
      end
      7'b1101111: begin
        issue.src1 = pc;
        issue.src2 = imm_j;
        issue.imm  = imm_j;
      end
      7'b1100111, 7'b0000011, 7'b0010011, 7'b0011011: issue.src2 = imm_i;
      7'b1100011: issue.imm = imm_b;
      7'b0100011: issue.imm = imm_s;
      default: ;
    endcase
  end

  // once halted, issue a nop to x0
  assign issue.op = halted ? rv_pkg::op_addi : dec_op;
  assign issue.rd = halted ? 5'd0 : inst[11:7];
  assign issue.pc = pc;

  assign illegal = !halted && (dec_op == rv_pkg::op_illegal);

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::reg_idx_t    raddr1,
  input  rv_pkg::reg_idx_t    raddr2,
  output logic [`RV_XLEN-1:0] rdata1,
  output logic [`RV_XLEN-1:0] rdata2,
  input  logic                wen,
  input  rv_pkg::reg_idx_t    waddr,
  input  logic [`RV_XLEN-1:0] wdata
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads with x0 reading as zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- verilog/rv_stage_if.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// decoded instruction handed from decode to execute
interface issue_if;
  rv_pkg::op_e         op;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] pc;
  rv_pkg::reg_idx_t    rd;

  modport producer (output op, src1, src2, imm, pc, rd);
  modport consumer (input op, src1, src2, imm, pc, rd);
endinterface

// executed instruction handed from execute to result
interface commit_if;
  rv_pkg::op_e         op;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] addr;
  logic [`RV_XLEN-1:0] store_data;
  rv_pkg::reg_idx_t    rd;

  modport producer (output op, alu_result, addr, store_data, rd);
  modport consumer (input op, alu_result, addr, store_data, rd);
endinterface

//--- verilog/rv_pkg.sv
package rv_pkg;

  // every operation the core knows, grouped by instruction class
  typedef enum logic [5:0] {
    // upper immediates and jumps
    op_lui, op_auipc, op_jal, op_jalr,
    // branches
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    // loads
    op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
    // stores
    op_sb, op_sh, op_sw, op_sd,
    // register-immediate
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
    op_slli, op_srli, op_srai,
    // register-register
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    // 32-bit word forms
    op_addiw, op_slliw, op_srliw, op_sraiw,
    op_addw, op_subw, op_sllw, op_srlw, op_sraw,
    // system
    op_ebreak,
    op_illegal
  } op_e;

  // access width of a load or store
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_double
  } mem_size_e;

  typedef logic [4:0] reg_idx_t;

endpackage

//--- verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// register and instruction widths
`define RV_XLEN 64
`define RV_ILEN 32

// first fetch address out of reset
`define RV_RESET_PC 64'h0

// sign-extend the low w bits of a plain signal to full register width
`define RV_SEXT(val, w) {{(`RV_XLEN - (w)){val[(w) - 1]}}, val[(w) - 1:0]}

`endif
